// File: common/erx_config.svh
`ifndef ERX_CONFIG_SVH
`define ERX_CONFIG_SVH

// chip ID of this node, low 6 bits are the column ID
`define ERX_ID          12'h808

// log2 of the column ID, used by the dynamic remap
`define ERX_COLID_LOG2  3

// packet width in bits
`define ERX_PW          104

// lane bytes per packet
`define ERX_PKT_BYTES   13

`endif

// File: common/erx_pkg.sv
`default_nettype none

package erx_pkg;

   // mesh packet, sent on the lane most significant byte first
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [7:0]  ctrl;     // bit 1 set = write
   } emesh_packet_t;

   // 2'b11 is not named, the remap stage treats it as dynamic
   typedef enum logic [1:0] {
      remap_none    = 2'd0,
      remap_static  = 2'd1,
      remap_dynamic = 2'd2
   } remap_mode_e;

   // remap settings from the config registers
   typedef struct packed {
      remap_mode_e mode;
      logic [11:0] sel;      // which top address bits get replaced
      logic [11:0] pattern;  // replacement bits for static mode
      logic [31:0] base;     // offset for dynamic mode
   } remap_cfg_t;

   // remapped packet on its way to the output stage
   typedef struct packed {
      emesh_packet_t packet;
      logic          mailbox;  // write hit our own ID
   } erx_txn_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+common
common/erx_pkg.sv
hw/erx_protocol.sv
hw/erx_cfg.sv
hw/erx_remap.sv
hw/erx_distrib.sv
hw/erx_core.sv
tests/erx_core_tb.sv

// File: hw/erx_cfg.sv
`default_nettype none

module erx_cfg (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cfg_write,
   input  logic [1:0]          cfg_addr,
   input  logic [31:0]         cfg_wdata,
   output erx_pkg::remap_cfg_t remap_cfg
);

   import erx_pkg::*;

   remap_cfg_t cfg_q;

   // four registers, each takes the low bits of the write data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_q.mode    <= remap_none;
         cfg_q.sel     <= '0;
         cfg_q.pattern <= '0;
         cfg_q.base    <= '0;
      end else if (cfg_write) begin
         case (cfg_addr)
            2'd0: cfg_q.mode    <= remap_mode_e'(cfg_wdata[1:0]);
            2'd1: cfg_q.sel     <= cfg_wdata[11:0];
            2'd2: cfg_q.pattern <= cfg_wdata[11:0];
            2'd3: cfg_q.base    <= cfg_wdata;
            default: ;
         endcase
      end
   end

   assign remap_cfg = cfg_q;  // visible the cycle after the strobe

endmodule

`default_nettype wire

// File: hw/erx_core.sv
`default_nettype none

`include "erx_config.svh"

module erx_core (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   lane_frame,
   input  logic [7:0]             lane_byte,
   input  logic                   cfg_write,
   input  logic [1:0]             cfg_addr,
   input  logic [31:0]            cfg_wdata,
   output logic                   wr_access,
   output logic                   rd_access,
   output logic                   mbx_access,
   output erx_pkg::emesh_packet_t out_packet
);

   import erx_pkg::*;

   logic          pkt_access;
   emesh_packet_t pkt;        // assembled from the lane
   remap_cfg_t    remap_cfg;
   logic          txn_access;
   erx_txn_t      txn;        // after address remap

   erx_protocol erx_protocol_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .lane_frame (lane_frame),
      .lane_byte  (lane_byte),
      .pkt_access (pkt_access),
      .pkt        (pkt)
   );

   erx_cfg erx_cfg_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .remap_cfg (remap_cfg)
   );

   erx_remap erx_remap_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_access (pkt_access),
      .pkt        (pkt),
      .remap_cfg  (remap_cfg),
      .txn_access (txn_access),
      .txn        (txn)
   );

   erx_distrib erx_distrib_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .txn_access (txn_access),
      .txn        (txn),
      .wr_access  (wr_access),
      .rd_access  (rd_access),
      .mbx_access (mbx_access),
      .out_packet (out_packet)
   );

endmodule

`default_nettype wire

// File: hw/erx_distrib.sv
`default_nettype none

module erx_distrib (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   txn_access,
   input  erx_pkg::erx_txn_t      txn,
   output logic                   wr_access,
   output logic                   rd_access,
   output logic                   mbx_access,
   output erx_pkg::emesh_packet_t out_packet
);

   import erx_pkg::*;

   logic          is_write;
   emesh_packet_t packet_q;

   assign is_write = txn.packet.ctrl[1];

   // exactly one channel per transaction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_access  <= 1'b0;
         rd_access  <= 1'b0;
         mbx_access <= 1'b0;
      end else begin
         wr_access  <= txn_access &  is_write & ~txn.mailbox;
         rd_access  <= txn_access & ~is_write;
         mbx_access <= txn_access &  is_write &  txn.mailbox;
      end
   end

   // shared payload, holds until the next transaction
   always_ff @(posedge clk) begin
      if (txn_access) begin
         packet_q <= txn.packet;
      end
   end

   assign out_packet = packet_q;

endmodule

`default_nettype wire

// File: hw/erx_protocol.sv
`default_nettype none

`include "erx_config.svh"

module erx_protocol (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  lane_frame,
   input  logic [7:0]            lane_byte,
   output logic                  pkt_access,
   output erx_pkg::emesh_packet_t pkt
);

   import erx_pkg::*;

   logic [3:0]    byte_cnt;  // bytes of the current packet seen so far
   emesh_packet_t shift_q;   // assembles bytes msb first
   logic          last_byte;

   assign last_byte = lane_frame && (byte_cnt == 4'(`ERX_PKT_BYTES - 1));

   // count framed bytes, a frame drop throws the partial packet away
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         byte_cnt   <= '0;
         pkt_access <= 1'b0;
      end else begin
         pkt_access <= last_byte;        // one cycle after the 13th byte
         if (!lane_frame)
            byte_cnt <= '0;
         else if (last_byte)
            byte_cnt <= '0;              // back to back packets allowed
         else
            byte_cnt <= byte_cnt + 4'd1;
      end
   end

   // payload path
   always_ff @(posedge clk) begin
      if (lane_frame) begin
         shift_q <= {shift_q[`ERX_PW-9:0], lane_byte};
      end
   end

   // shift_q holds the full packet in the strobe cycle,
   // the next byte only lands one edge later
   assign pkt = shift_q;

endmodule

`default_nettype wire

// File: hw/erx_remap.sv
`default_nettype none

`include "erx_config.svh"

module erx_remap (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pkt_access,
   input  erx_pkg::emesh_packet_t pkt,
   input  erx_pkg::remap_cfg_t    remap_cfg,
   output logic                   txn_access,
   output erx_pkg::erx_txn_t      txn
);

   import erx_pkg::*;

   localparam logic [5:0] colid = 6'(`ERX_ID);  // low bits of the chip ID

   logic [31:0] addr_in;
   logic        id_match;   // address points at this chip
   logic [31:0] static_addr;
   logic [31:0] dynamic_addr;
   logic [31:0] remap_addr;
   erx_txn_t    txn_next;

   assign addr_in  = pkt.dstaddr;
   assign id_match = (addr_in[31:20] == `ERX_ID);

   // substitute selected high bits
   assign static_addr[31:20] = (remap_cfg.sel & remap_cfg.pattern) |
                               (~remap_cfg.sel & addr_in[31:20]);
   assign static_addr[19:0]  = addr_in[19:0];

   // compress the address space onto the base, wraps mod 2^32
   assign dynamic_addr = addr_in
                       - (32'(colid) << 20)
                       + remap_cfg.base
                       - (32'(addr_in[31:26]) << `ERX_COLID_LOG2);

   always_comb begin
      if (id_match) begin
         remap_addr = addr_in;             // own mailbox space is never remapped
      end else begin
         case (remap_cfg.mode)
            remap_none:   remap_addr = addr_in;
            remap_static: remap_addr = static_addr;
            default:      remap_addr = dynamic_addr;  // 2 and 3
         endcase
      end
   end

   always_comb begin
      txn_next                = '{packet: pkt, mailbox: id_match & pkt.ctrl[1]};
      txn_next.packet.dstaddr = remap_addr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         txn_access <= 1'b0;
      else
         txn_access <= pkt_access;
   end

   always_ff @(posedge clk) begin
      if (pkt_access) begin
         txn <= txn_next;
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the erx_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module erx_core_tb -f filelist.f -o erx_sim > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/erx_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; } \
   || { grep -q "Done: no errors" sim.log && echo "simulation passed"; }

// File: tests/erx_core_tb.sv
`default_nettype none

`include "erx_config.svh"

module erx_core_tb;

   import erx_pkg::*;

   localparam int DRV_DLY = 10;   // inputs change this long after the rising edge
   localparam int TIMEOUT = 20;   // cycles

   // one packet the monitor is waiting for
   typedef struct packed {
      logic [7:0]    chan;        // w, r or m
      emesh_packet_t pkt;
      logic [31:0]   cycle;       // strobe must show up in this cycle
   } expect_t;

   logic          clk;
   logic          rst_n;
   logic          lane_frame;
   logic [7:0]    lane_byte;
   logic          cfg_write;
   logic [1:0]    cfg_addr;
   logic [31:0]   cfg_wdata;
   logic          wr_access;
   logic          rd_access;
   logic          mbx_access;
   emesh_packet_t out_packet;

   expect_t    exp_q[$];
   int         cycle_cnt;
   int         mon_errors;
   int         drv_errors;
   int         checks;
   int         tests;
   int         failed;
   int         test_base;
   string      test_name;
   integer     seed;
   remap_cfg_t cfg_copy;    // mirror of the DUT config, only printed

   erx_core erx_core_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         cycle_cnt <= 0;
      else
         cycle_cnt <= cycle_cnt + 1;
   end

   function automatic int total_errors();
      return mon_errors + drv_errors;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         mon_errors++;
         $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, expected);
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      expect_t    e;
      logic [7:0] seen;
      if (!rst_n) begin
         mon_errors = 0;
         checks     = 0;
      end else if (wr_access || rd_access || mbx_access) begin
         seen = "w";
         if (rd_access) seen = "r";
         if (mbx_access) seen = "m";
         if (exp_q.size() == 0) begin
            mon_errors++;
            $display("t=%0t a strobe came out although no packet was sent", $time);
         end else begin
            e = exp_q.pop_front();
            check_value("strobe count", 32'(wr_access) + 32'(rd_access) + 32'(mbx_access), 1);
            check_value("channel", 32'(seen), 32'(e.chan));
            check_value("srcaddr", out_packet.srcaddr, e.pkt.srcaddr);
            check_value("data", out_packet.data, e.pkt.data);
            check_value("dstaddr", out_packet.dstaddr, e.pkt.dstaddr);
            check_value("ctrl", 32'(out_packet.ctrl), 32'(e.pkt.ctrl));
            check_value("strobe cycle", 32'(cycle_cnt), e.cycle);
         end
      end
   end

   // msb first, nbytes below 13 leaves a partial packet
   task automatic send_packet(input emesh_packet_t pkt, input int nbytes, output int last);
      for (int i = 0; i < nbytes; i++) begin
         @(posedge clk);
         #DRV_DLY;
         lane_frame = 1'b1;
         lane_byte  = pkt[`ERX_PW-1-8*i -: 8];
         last       = cycle_cnt;       // cycle this byte sits on the lane
      end
   endtask

   task automatic close_frame();
      @(posedge clk);
      #DRV_DLY;
      lane_frame = 1'b0;
      lane_byte  = '0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         drv_errors++;
         $display("t=%0t timeout, %0d packet(s) never came out", $time, exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic write_cfg(input logic [1:0] addr, input logic [31:0] data);
      @(posedge clk);
      #DRV_DLY;
      cfg_write = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(posedge clk);
      #DRV_DLY;
      cfg_write = 1'b0;
      case (addr)
         2'd0: cfg_copy.mode    = remap_mode_e'(data[1:0]);
         2'd1: cfg_copy.sel     = data[11:0];
         2'd2: cfg_copy.pattern = data[11:0];
         default: cfg_copy.base = data;
      endcase
   endtask

   task automatic report_test();
      if (test_name.len() != 0) begin
         tests++;
         if (total_errors() == test_base) begin
            $display("test %0d %s: pass, remap mode %0d", tests, test_name, cfg_copy.mode);
         end else begin
            failed++;
            $display("test %0d %s: failed with %0d error(s)", tests, test_name,
                     total_errors() - test_base);
         end
      end
      test_base = total_errors();
   endtask

   initial begin
      int            fd;
      int            n;
      int            last;
      int            gap;
      string         line;
      string         rest;
      logic [7:0]    kind;
      logic [31:0]   f[5];
      emesh_packet_t pkt;
      expect_t       e;
      lane_frame = 1'b0;
      lane_byte  = '0;
      cfg_write  = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      rst_n      = 1'b0;
      seed       = 32'h13b8;
      drv_errors = 0;
      tests      = 0;
      failed     = 0;
      test_base  = 0;
      test_name  = "";
      cfg_copy   = '0;
      repeat (16) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;
      fd = $fopen("tests/erx_stimulus.txt", "r");
      if (fd == 0) begin
         drv_errors++;
         $display("could not open tests/erx_stimulus.txt");
      end
      while (fd != 0 && !$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && line.getc(line.len() - 1) == "\n")
            line = line.substr(0, line.len() - 2);
         if (n <= 0 || line.len() == 0)
            continue;
         kind = line.getc(0);
         rest = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
         case (kind)
            "t": begin
               report_test();
               test_name = rest;
            end
            "i": begin
               n = $sscanf(rest, "%d", gap);
               repeat (gap) @(posedge clk);   // monitor flags any strobe
            end
            "c": begin
               n = $sscanf(rest, "%h %h", f[0], f[1]);
               write_cfg(f[0][1:0], f[1]);
            end
            "d": begin
               n = $sscanf(rest, "%h %h %h %h", f[0], f[1], f[2], f[3]);
               pkt = {f[0], f[1], f[2], f[3][7:0]};
               send_packet(pkt, 7, last);
               close_frame();
               repeat (TIMEOUT) @(posedge clk);
            end
            "p", "b": begin
               n = $sscanf(rest.substr(2, rest.len() - 1), "%h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4]);
               if (n != 5) begin
                  drv_errors++;
                  $display("stimulus line is malformed: %s", line);
               end
               pkt = {f[0], f[1], f[2], f[3][7:0]};
               if (kind == "p") begin
                  gap = int'($unsigned($random(seed)) % 32'd4);
                  repeat (gap) @(posedge clk);
               end
               send_packet(pkt, `ERX_PKT_BYTES, last);
               e.chan        = rest.getc(0);
               e.pkt         = pkt;
               e.pkt.dstaddr = f[4];
               e.cycle       = 32'(last + 3);   // three register stages
               exp_q.push_back(e);
               if (kind == "p") begin
                  close_frame();
                  wait_drain();
               end
            end
            "e": begin
               close_frame();
               wait_drain();
            end
            default: ;
         endcase
      end
      if (fd != 0)
         $fclose(fd);
      report_test();
      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks,
               total_errors());
      if (total_errors() == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/erx_stimulus.txt
# t name | i idle_cycles | c addr data | d src data dst ctrl (frame drops after 7 bytes) | e
# p/b chan src data dst ctrl expected_dst (p own frame after a random gap, b frame held high)
t reset_read
i 10
p r 11223344 deadbeef 12345678 00 12345678
t static_write
c 0 1
c 1 f00
c 2 a5c
p w 00000abc 0badf00d 3c0abcde 02 ac0abcde
p w 00000abd cafe0001 fff00010 0a aff00010
t dynamic_remap
c 0 2
c 3 80000000
p w 00000100 00000001 81000040 02 007fff40
p r 00000101 00000002 20000010 00 9f7fffd0
p w 00000102 00000003 00100000 02 7f900000
t mailbox_hit
p m 00000200 12345678 80800100 02 80800100
p r 00000201 00000000 80800100 00 80800100
t frame_drop
c 0 0
d 00000300 11111111 40000000 02
p w 00000301 22222222 55667788 02 55667788
t back_to_back
b w a0000001 00000001 10000000 02 10000000
b m a0000002 00000002 80812345 02 80812345
b r a0000003 00000003 20000000 00 20000000
e
